/* source/memPipePkg.sv */
// ###############################################
// Shared widths, op kinds and address map for the
// two-stage memory pipeline. Every block refers to
// these by scoped name.
// ###############################################

package memPipePkg;

    // Datapath widths
    localparam int dataWidth = 32;
    localparam int addrWidth = 16;

    // Low address bits that index the data RAM
    localparam int ramIndexWidth = 8;

    // Low address bits that select an IO register
    localparam int ioIndexWidth = 2;

    // Set in the word address means the IO region
    localparam int ioRegionBit = 15;

    // Destination register tag
    localparam int dstWidth = 5;

    // Circular active-list pointer
    localparam int ptrWidth = 4;

    // Memory micro-op kinds
    typedef enum logic [1:0] {
        opLoad  = 2'd0,
        opStore = 2'd1,
        opCsr   = 2'd2,
        opAddr  = 2'd3
    } opKind;

    // True when ptr lies in [head, tail) on the circular active list.
    // An equal head and tail means nothing is flushed
    function automatic logic inFlushRange(
        input logic                flushValid,
        input logic [ptrWidth-1:0] head,
        input logic [ptrWidth-1:0] tail,
        input logic [ptrWidth-1:0] ptr
    );
        logic inRange;
        if (head < tail) begin
            inRange = (ptr >= head) && (ptr < tail);
        end
        else if (head > tail) begin
            // Range wraps past the top pointer value
            inRange = (ptr >= head) || (ptr < tail);
        end
        else begin
            inRange = 1'b0;
        end
        return flushValid && inRange;
    endfunction

endpackage

/* source/dataMemory.sv */
// ###############################################
// 256-word data RAM with one write port and a
// registered read port. The read register only
// loads on ramRead so a stalled load keeps its word.
// ###############################################

module dataMemory (
    input  logic                                   clk,
    input  logic                                   ramWrite,
    input  logic                                   ramRead,
    input  logic [memPipePkg::ramIndexWidth-1:0]   ramIndex,
    input  logic [memPipePkg::dataWidth-1:0]       ramWriteData,
    output logic [memPipePkg::dataWidth-1:0]       ramReadData
);

    logic [memPipePkg::dataWidth-1:0] mem [2**memPipePkg::ramIndexWidth];

    // Start from a known all-zero image in simulation
    initial begin
        for (int i = 0; i < 2**memPipePkg::ramIndexWidth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ramWrite) begin
            mem[ramIndex] <= ramWriteData;
        end
    end

    // Read returns the old word if written on the same edge
    always_ff @(posedge clk) begin
        if (ramRead) begin
            ramReadData <= mem[ramIndex];
        end
    end

endmodule

/* source/ioRegisters.sv */
// ###############################################
// Four memory-mapped device registers. Stores write
// on the clock edge, loads read them combinationally
// from the memory-access stage.
// ###############################################

module ioRegisters (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  ioWrite,
    input  logic [memPipePkg::ioIndexWidth-1:0]   ioIndex,
    input  logic [memPipePkg::dataWidth-1:0]      ioWriteData,
    input  logic [memPipePkg::ioIndexWidth-1:0]   ioReadIndex,
    output logic [memPipePkg::dataWidth-1:0]      ioReadData
);

    logic [memPipePkg::dataWidth-1:0] devReg [2**memPipePkg::ioIndexWidth];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**memPipePkg::ioIndexWidth; i++) begin
                devReg[i] <= '0;
            end
        end
        else if (ioWrite) begin
            devReg[ioIndex] <= ioWriteData;
        end
    end

    assign ioReadData = devReg[ioReadIndex];

endmodule

/* source/memTagAccessStage.sv */
// ###############################################
// Tag-access stage. Takes one op per cycle on a
// valid/ready input, tags IO addresses, performs
// stores and starts the RAM read as the op moves on.
// ###############################################

module memTagAccessStage (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   clear,
    input  logic                                   flushValid,
    input  logic [memPipePkg::ptrWidth-1:0]        flushHead,
    input  logic [memPipePkg::ptrWidth-1:0]        flushTail,
    input  logic                                   inValid,
    input  memPipePkg::opKind                      inKind,
    input  logic [memPipePkg::addrWidth-1:0]       inAddr,
    input  logic [memPipePkg::dataWidth-1:0]       inStoreData,
    input  logic [memPipePkg::dataWidth-1:0]       inCsrData,
    input  logic [memPipePkg::dstWidth-1:0]        inDst,
    input  logic [memPipePkg::ptrWidth-1:0]        inPtr,
    input  logic                                   s2Accept,
    output logic                                   inReady,
    output logic                                   s1Valid,
    output memPipePkg::opKind                      s1Kind,
    output logic [memPipePkg::addrWidth-1:0]       s1Addr,
    output logic                                   s1IsIo,
    output logic [memPipePkg::dataWidth-1:0]       s1CsrData,
    output logic [memPipePkg::dstWidth-1:0]        s1Dst,
    output logic [memPipePkg::ptrWidth-1:0]        s1Ptr,
    output logic                                   ramWrite,
    output logic                                   ramRead,
    output logic [memPipePkg::ramIndexWidth-1:0]   ramIndex,
    output logic [memPipePkg::dataWidth-1:0]       ramWriteData,
    output logic                                   ioWrite,
    output logic [memPipePkg::ioIndexWidth-1:0]    ioIndex,
    output logic [memPipePkg::dataWidth-1:0]       ioWriteData
);

    logic                             slotValid;
    logic [memPipePkg::dataWidth-1:0] storeData;
    logic                             flushed;
    logic                             advance;
    logic                             storeLeaving;

    assign flushed = memPipePkg::inFlushRange(flushValid, flushHead, flushTail, s1Ptr);

    // A flushed op is hidden from stage 2 and simply dropped here
    assign s1Valid = slotValid && !flushed;
    assign advance = s1Valid && s2Accept;

    // Slot frees when empty, flushed or moving on; hold off new ops during clear
    assign inReady = !clear && (!slotValid || flushed || s2Accept);

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= 1'b0;
        end
        else if (clear) begin
            slotValid <= 1'b0;
        end
        else if (inReady) begin
            slotValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            s1Kind    <= inKind;
            s1Addr    <= inAddr;
            s1IsIo    <= inAddr[memPipePkg::ioRegionBit];
            storeData <= inStoreData;
            s1CsrData <= inCsrData;
            s1Dst     <= inDst;
            s1Ptr     <= inPtr;
        end
    end

    // Memory side effects happen on the edge the op leaves
    assign storeLeaving = advance && !clear && (s1Kind == memPipePkg::opStore);

    assign ramRead      = advance;
    assign ramWrite     = storeLeaving && !s1IsIo;
    assign ramIndex     = s1Addr[memPipePkg::ramIndexWidth-1:0];
    assign ramWriteData = storeData;

    assign ioWrite     = storeLeaving && s1IsIo;
    assign ioIndex     = s1Addr[memPipePkg::ioIndexWidth-1:0];
    assign ioWriteData = storeData;

endmodule

/* source/memoryAccessStage.sv */
// ###############################################
// Memory-access stage. Picks the op's result from
// load data, IO data, the carried CSR value or the
// address, drives the bypass and hands the result
// to write-back under valid/ready back-pressure.
// ###############################################

module memoryAccessStage (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  clear,
    input  logic                                  flushValid,
    input  logic [memPipePkg::ptrWidth-1:0]       flushHead,
    input  logic [memPipePkg::ptrWidth-1:0]       flushTail,
    input  logic                                  s1Valid,
    input  memPipePkg::opKind                     s1Kind,
    input  logic [memPipePkg::addrWidth-1:0]      s1Addr,
    input  logic                                  s1IsIo,
    input  logic [memPipePkg::dataWidth-1:0]      s1CsrData,
    input  logic [memPipePkg::dstWidth-1:0]       s1Dst,
    input  logic [memPipePkg::ptrWidth-1:0]       s1Ptr,
    input  logic [memPipePkg::dataWidth-1:0]      ramReadData,
    input  logic [memPipePkg::dataWidth-1:0]      ioReadData,
    input  logic                                  wbReady,
    output logic                                  s2Accept,
    output logic [memPipePkg::ioIndexWidth-1:0]   ioReadIndex,
    output logic                                  wbValid,
    output logic [memPipePkg::dataWidth-1:0]      wbData,
    output logic [memPipePkg::dstWidth-1:0]       wbDst,
    output logic [memPipePkg::ptrWidth-1:0]       wbPtr,
    output logic                                  bypassValid,
    output logic [memPipePkg::dstWidth-1:0]       bypassDst,
    output logic [memPipePkg::dataWidth-1:0]      bypassData
);

    logic                             slotValid;
    memPipePkg::opKind                kind;
    logic [memPipePkg::addrWidth-1:0] addr;
    logic                             isIo;
    logic [memPipePkg::dataWidth-1:0] csrData;
    logic                             flushed;
    logic                             live;
    logic [memPipePkg::dataWidth-1:0] result;

    assign flushed = memPipePkg::inFlushRange(flushValid, flushHead, flushTail, wbPtr);

    // Op is visible only while neither flush nor clear is dropping it
    assign live = slotValid && !flushed && !clear;

    // Free when empty, when a flushed op vanishes, or when write-back takes it
    assign s2Accept = !slotValid || flushed || wbReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= 1'b0;
        end
        else if (clear) begin
            slotValid <= 1'b0;
        end
        else if (s2Accept) begin
            slotValid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1Valid && s2Accept) begin
            kind    <= s1Kind;
            addr    <= s1Addr;
            isIo    <= s1IsIo;
            csrData <= s1CsrData;
            wbDst   <= s1Dst;
            wbPtr   <= s1Ptr;
        end
    end

    assign ioReadIndex = addr[memPipePkg::ioIndexWidth-1:0];

    always_comb begin
        result = '0;
        case (kind)
            memPipePkg::opLoad: begin
                result = isIo ? ioReadData : ramReadData;
            end
            memPipePkg::opCsr: begin
                result = csrData;
            end
            // Stores and address ops report the address itself
            memPipePkg::opStore, memPipePkg::opAddr: begin
                result = {{(memPipePkg::dataWidth - memPipePkg::addrWidth){1'b0}}, addr};
            end
        endcase
    end

    assign wbValid = live;
    assign wbData  = result;

    // Bypass ignores wbReady
    assign bypassValid = live;
    assign bypassDst   = wbDst;
    assign bypassData  = result;

endmodule

/* source/memPipeTop.sv */
// ###############################################
// Top of the memory pipeline. Wires the tag-access
// stage, data RAM, IO registers and memory-access
// stage between the op input and write-back port.
// ###############################################

module memPipeTop (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              inValid,
    output logic                              inReady,
    input  memPipePkg::opKind                 inKind,
    input  logic [memPipePkg::addrWidth-1:0]  inAddr,
    input  logic [memPipePkg::dataWidth-1:0]  inStoreData,
    input  logic [memPipePkg::dataWidth-1:0]  inCsrData,
    input  logic [memPipePkg::dstWidth-1:0]   inDst,
    input  logic [memPipePkg::ptrWidth-1:0]   inPtr,
    output logic                              wbValid,
    input  logic                              wbReady,
    output logic [memPipePkg::dataWidth-1:0]  wbData,
    output logic [memPipePkg::dstWidth-1:0]   wbDst,
    output logic [memPipePkg::ptrWidth-1:0]   wbPtr,
    output logic                              bypassValid,
    output logic [memPipePkg::dstWidth-1:0]   bypassDst,
    output logic [memPipePkg::dataWidth-1:0]  bypassData,
    input  logic                              flushValid,
    input  logic [memPipePkg::ptrWidth-1:0]   flushHead,
    input  logic [memPipePkg::ptrWidth-1:0]   flushTail,
    input  logic                              clear
);

    // Stage 1 to stage 2
    logic                                 s1Valid;
    memPipePkg::opKind                    s1Kind;
    logic [memPipePkg::addrWidth-1:0]     s1Addr;
    logic                                 s1IsIo;
    logic [memPipePkg::dataWidth-1:0]     s1CsrData;
    logic [memPipePkg::dstWidth-1:0]      s1Dst;
    logic [memPipePkg::ptrWidth-1:0]      s1Ptr;
    logic                                 s2Accept;

    // RAM and IO ports
    logic                                 ramWrite;
    logic                                 ramRead;
    logic [memPipePkg::ramIndexWidth-1:0] ramIndex;
    logic [memPipePkg::dataWidth-1:0]     ramWriteData;
    logic [memPipePkg::dataWidth-1:0]     ramReadData;
    logic                                 ioWrite;
    logic [memPipePkg::ioIndexWidth-1:0]  ioIndex;
    logic [memPipePkg::dataWidth-1:0]     ioWriteData;
    logic [memPipePkg::ioIndexWidth-1:0]  ioReadIndex;
    logic [memPipePkg::dataWidth-1:0]     ioReadData;

    memTagAccessStage u_memTagAccessStage (
        .clk(clk), .rst(rst), .clear(clear),
        .flushValid(flushValid), .flushHead(flushHead), .flushTail(flushTail),
        .inValid(inValid), .inKind(inKind), .inAddr(inAddr),
        .inStoreData(inStoreData), .inCsrData(inCsrData),
        .inDst(inDst), .inPtr(inPtr), .s2Accept(s2Accept),
        .inReady(inReady), .s1Valid(s1Valid), .s1Kind(s1Kind),
        .s1Addr(s1Addr), .s1IsIo(s1IsIo), .s1CsrData(s1CsrData),
        .s1Dst(s1Dst), .s1Ptr(s1Ptr),
        .ramWrite(ramWrite), .ramRead(ramRead), .ramIndex(ramIndex),
        .ramWriteData(ramWriteData),
        .ioWrite(ioWrite), .ioIndex(ioIndex), .ioWriteData(ioWriteData)
    );

    dataMemory u_dataMemory (
        .clk(clk), .ramWrite(ramWrite), .ramRead(ramRead),
        .ramIndex(ramIndex), .ramWriteData(ramWriteData),
        .ramReadData(ramReadData)
    );

    ioRegisters u_ioRegisters (
        .clk(clk), .rst(rst), .ioWrite(ioWrite), .ioIndex(ioIndex),
        .ioWriteData(ioWriteData), .ioReadIndex(ioReadIndex),
        .ioReadData(ioReadData)
    );

    memoryAccessStage u_memoryAccessStage (
        .clk(clk), .rst(rst), .clear(clear),
        .flushValid(flushValid), .flushHead(flushHead), .flushTail(flushTail),
        .s1Valid(s1Valid), .s1Kind(s1Kind), .s1Addr(s1Addr),
        .s1IsIo(s1IsIo), .s1CsrData(s1CsrData), .s1Dst(s1Dst),
        .s1Ptr(s1Ptr), .ramReadData(ramReadData), .ioReadData(ioReadData),
        .wbReady(wbReady), .s2Accept(s2Accept), .ioReadIndex(ioReadIndex),
        .wbValid(wbValid), .wbData(wbData), .wbDst(wbDst), .wbPtr(wbPtr),
        .bypassValid(bypassValid), .bypassDst(bypassDst),
        .bypassData(bypassData)
    );

endmodule

/* test/memPipeTb.sv */
// ###############################################
// Testbench for the memory pipeline. Runs a table
// of ops under random write-back stalls, then a
// selective flush and a clear, and checks every
// result in order.
// ###############################################

module memPipeTb;

    localparam int tableLen    = 16;
    localparam int cycleLimit  = tableLen * 8 + 100;
    localparam int readyLow    = 0;
    localparam int readyHigh   = 1;
    localparam int readyRandom = 2;

    logic                                 clk;
    logic                                 rst;
    logic                                 inValid;
    logic                                 inReady;
    memPipePkg::opKind                    inKind;
    logic [memPipePkg::addrWidth-1:0]     inAddr;
    logic [memPipePkg::dataWidth-1:0]     inStoreData;
    logic [memPipePkg::dataWidth-1:0]     inCsrData;
    logic [memPipePkg::dstWidth-1:0]      inDst;
    logic [memPipePkg::ptrWidth-1:0]      inPtr;
    logic                                 wbValid;
    logic                                 wbReady;
    logic [memPipePkg::dataWidth-1:0]     wbData;
    logic [memPipePkg::dstWidth-1:0]      wbDst;
    logic [memPipePkg::ptrWidth-1:0]      wbPtr;
    logic                                 bypassValid;
    logic [memPipePkg::dstWidth-1:0]      bypassDst;
    logic [memPipePkg::dataWidth-1:0]     bypassData;
    logic                                 flushValid;
    logic [memPipePkg::ptrWidth-1:0]      flushHead;
    logic [memPipePkg::ptrWidth-1:0]      flushTail;
    logic                                 clear;

    // Row is {kind, addr, store data, CSR data, expected wbData}
    logic [113:0] opTable [tableLen];

    // Reference memory contents seen by the ops that really complete
    logic [memPipePkg::dataWidth-1:0] ramModel [256];
    logic [memPipePkg::dataWidth-1:0] ioModel [4];

    logic [memPipePkg::dataWidth-1:0] expData [$];
    logic [memPipePkg::dstWidth-1:0]  expDst [$];
    logic [memPipePkg::ptrWidth-1:0]  expPtr [$];
    string                            expName [$];

    int                               readyMode  = readyLow;
    int                               cycleCount = 0;
    logic                             prevValid  = 1'b0;
    logic                             prevReady  = 1'b0;
    logic [memPipePkg::dataWidth-1:0] prevData   = '0;

    memPipeTop u_memPipeTop (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inReady(inReady), .inKind(inKind), .inAddr(inAddr),
        .inStoreData(inStoreData), .inCsrData(inCsrData), .inDst(inDst), .inPtr(inPtr),
        .wbValid(wbValid), .wbReady(wbReady), .wbData(wbData), .wbDst(wbDst),
        .wbPtr(wbPtr), .bypassValid(bypassValid), .bypassDst(bypassDst),
        .bypassData(bypassData), .flushValid(flushValid), .flushHead(flushHead),
        .flushTail(flushTail), .clear(clear)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    // Advance to the next falling edge and drive wbReady for the new cycle
    task automatic tick();
        @(negedge clk);
        if (readyMode == readyRandom) begin
            wbReady = ($urandom % 2) == 1;
        end
        else begin
            wbReady = (readyMode == readyHigh);
        end
    endtask

    task automatic setReady(input int mode);
        readyMode = mode;
        if (mode == readyRandom) begin
            wbReady = ($urandom % 2) == 1;
        end
        else begin
            wbReady = (mode == readyHigh);
        end
    endtask

    function automatic logic [memPipePkg::dataWidth-1:0] modelLoad(
        input logic [memPipePkg::addrWidth-1:0] addr
    );
        if (addr[memPipePkg::ioRegionBit]) begin
            return ioModel[addr[memPipePkg::ioIndexWidth-1:0]];
        end
        return ramModel[addr[memPipePkg::ramIndexWidth-1:0]];
    endfunction

    task automatic fillTable();
        opTable[0]  = {memPipePkg::opStore, 16'h0010, 32'hA5A5_0001, 32'h0, 32'h0000_0010};
        opTable[1]  = {memPipePkg::opLoad,  16'h0010, 32'h0, 32'h0, 32'hA5A5_0001};
        opTable[2]  = {memPipePkg::opCsr,   16'h0000, 32'h0, 32'hCAFE_F00D, 32'hCAFE_F00D};
        opTable[3]  = {memPipePkg::opAddr,  16'h1234, 32'h0, 32'h0, 32'h0000_1234};
        opTable[4]  = {memPipePkg::opStore, 16'h8001, 32'h1111_2222, 32'h0, 32'h0000_8001};
        opTable[5]  = {memPipePkg::opLoad,  16'h8001, 32'h0, 32'h0, 32'h1111_2222};
        opTable[6]  = {memPipePkg::opStore, 16'h0001, 32'h3333_4444, 32'h0, 32'h0000_0001};
        opTable[7]  = {memPipePkg::opLoad,  16'h0001, 32'h0, 32'h0, 32'h3333_4444};
        opTable[8]  = {memPipePkg::opLoad,  16'h8001, 32'h0, 32'h0, 32'h1111_2222};
        opTable[9]  = {memPipePkg::opLoad,  16'h0055, 32'h0, 32'h0, 32'h0000_0000};
        opTable[10] = {memPipePkg::opStore, 16'h0010, 32'h0BAD_BEEF, 32'h0, 32'h0000_0010};
        opTable[11] = {memPipePkg::opStore, 16'h0011, 32'h1234_5678, 32'h0, 32'h0000_0011};
        opTable[12] = {memPipePkg::opLoad,  16'h0010, 32'h0, 32'h0, 32'h0BAD_BEEF};
        opTable[13] = {memPipePkg::opLoad,  16'h0011, 32'h0, 32'h0, 32'h1234_5678};
        opTable[14] = {memPipePkg::opCsr,   16'h0000, 32'h0, 32'h00C0_FFEE, 32'h00C0_FFEE};
        opTable[15] = {memPipePkg::opAddr,  16'hFFFE, 32'h0, 32'h0, 32'h0000_FFFE};
    endtask

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic sendOp(
        input memPipePkg::opKind                kind,
        input logic [memPipePkg::addrWidth-1:0] addr,
        input logic [memPipePkg::dataWidth-1:0] storeData,
        input logic [memPipePkg::dataWidth-1:0] csrData,
        input logic [memPipePkg::dstWidth-1:0]  dst,
        input logic [memPipePkg::ptrWidth-1:0]  ptr,
        input logic                             expectOut,
        input logic [memPipePkg::dataWidth-1:0] expValue,
        input string                            name
    );
        logic accepted;
        if (expectOut) begin
            expData.push_back(expValue);
            expDst.push_back(dst);
            expPtr.push_back(ptr);
            expName.push_back(name);
            if (kind == memPipePkg::opStore && addr[memPipePkg::ioRegionBit]) begin
                ioModel[addr[memPipePkg::ioIndexWidth-1:0]] = storeData;
            end
            else if (kind == memPipePkg::opStore) begin
                ramModel[addr[memPipePkg::ramIndexWidth-1:0]] = storeData;
            end
        end
        inValid     = 1'b1;
        inKind      = kind;
        inAddr      = addr;
        inStoreData = storeData;
        inCsrData   = csrData;
        inDst       = dst;
        inPtr       = ptr;
        accepted    = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = inReady;
            tick();
        end
        inValid = 1'b0;
    endtask

    task automatic drain();
        while (expData.size() > 0) begin
            tick();
        end
        // A few more cycles so a stray extra result still gets caught
        repeat (4) tick();
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            failRun($sformatf("timeout: the run did not finish within %0d cycles", cycleLimit));
        end
    end

    // Result collector and write-back port checks
    always @(posedge clk) begin : collect
        logic [memPipePkg::dataWidth-1:0] want;
        logic [memPipePkg::dstWidth-1:0]  wantDst;
        logic [memPipePkg::ptrWidth-1:0]  wantPtr;
        string                            name;
        if (!rst) begin
            assert (bypassValid == wbValid
                    && (!wbValid || (bypassData == wbData && bypassDst == wbDst)))
                else failRun("the bypass outputs did not match the stage 2 result");
            if (prevValid && !prevReady && wbValid) begin
                assert (wbData == prevData)
                    else failRun($sformatf("error: stall hold expected %h actual %h",
                                           prevData, wbData));
            end
            if (wbValid && wbReady) begin
                assert (expData.size() > 0)
                    else failRun("a result came out that no outstanding op should produce");
                want    = expData.pop_front();
                wantDst = expDst.pop_front();
                wantPtr = expPtr.pop_front();
                name    = expName.pop_front();
                assert (wbData == want)
                    else failRun($sformatf("error: %s expected %h actual %h",
                                           name, want, wbData));
                assert (wbDst == wantDst)
                    else failRun($sformatf("error: %s dst expected %0d actual %0d",
                                           name, wantDst, wbDst));
                assert (wbPtr == wantPtr)
                    else failRun($sformatf("error: %s ptr expected %0d actual %0d",
                                           name, wantPtr, wbPtr));
            end
            prevValid = wbValid;
            prevReady = wbReady;
            prevData  = wbData;
        end
    end

    initial begin
        logic [113:0] row;
        void'($urandom(32'h42d2f2c3));
        rst         = 1'b1;
        inValid     = 1'b0;
        inKind      = memPipePkg::opLoad;
        inAddr      = '0;
        inStoreData = '0;
        inCsrData   = '0;
        inDst       = '0;
        inPtr       = '0;
        wbReady     = 1'b0;
        flushValid  = 1'b0;
        flushHead   = '0;
        flushTail   = '0;
        clear       = 1'b0;
        for (int i = 0; i < 256; i++) begin
            ramModel[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            ioModel[i] = '0;
        end
        fillTable();
        repeat (4) @(negedge clk);
        rst = 1'b0;

        assert (!wbValid && !bypassValid && inReady)
            else failRun("after reset the pipeline was not idle and ready for an op");

        // Table under random write-back stalls
        setReady(readyRandom);
        for (int i = 0; i < tableLen; i++) begin
            row = opTable[i];
            sendOp(memPipePkg::opKind'(row[113:112]), row[111:96], row[95:64], row[63:32],
                   5'(i + 1), 4'(i), 1'b1, row[31:0], $sformatf("table row %0d", i));
        end
        drain();

        // Op A parks in stage 2, store B in stage 1, then flush 14..1 hits only B
        setReady(readyLow);
        sendOp(memPipePkg::opAddr, 16'h0042, '0, '0, 5'd20, 4'd3, 1'b1, 32'h0000_0042,
               "flush survivor");
        sendOp(memPipePkg::opStore, 16'h0010, 32'hDEAD_0000, '0, 5'd21, 4'd14, 1'b0, '0, "");
        flushValid = 1'b1;
        flushHead  = 4'd14;
        flushTail  = 4'd2;
        tick();
        flushValid = 1'b0;
        setReady(readyHigh);
        sendOp(memPipePkg::opLoad, 16'h0010, '0, '0, 5'd22, 4'd4, 1'b1, modelLoad(16'h0010),
               "load after flushed store");
        drain();

        // Two ops in flight, then a one-cycle clear
        setReady(readyLow);
        sendOp(memPipePkg::opCsr, 16'h0000, '0, 32'h0000_0077, 5'd23, 4'd5, 1'b0, '0, "");
        sendOp(memPipePkg::opAddr, 16'h0099, '0, '0, 5'd24, 4'd6, 1'b0, '0, "");
        clear = 1'b1;
        tick();
        clear = 1'b0;
        setReady(readyHigh);
        sendOp(memPipePkg::opLoad, 16'h0011, '0, '0, 5'd25, 4'd7, 1'b1, modelLoad(16'h0011),
               "op after clear");
        drain();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* flist.f */
source/memPipePkg.sv
source/dataMemory.sv
source/ioRegisters.sv
source/memTagAccessStage.sv
source/memoryAccessStage.sv
source/memPipeTop.sv
test/memPipeTb.sv

/* Makefile */
# Verilator build, run, lint and clean for the memory pipeline

TOP := memPipeTb
LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module memPipeTop

clean:
	rm -rf obj_dir $(LOG)
